/* Makefile */
# Verilator build and run for the operand forwarding testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = issueOperandsTb
RTL_TOP   = issueOperands
FILELIST  = list.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

# the run passes only if the log holds the pass line
run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* dv/issueTests.svh */
`ifndef ISSUE_TESTS_SVH
`define ISSUE_TESTS_SVH

// no wakeups at all, operands come from the register file
task automatic rfOnlyIssue();
  testName = "rfOnlyIssue";
  repeat (4) begin
    advance();
    checks++;
    assert (outValid === 1'b0) else begin
      errors++;
      $display("%s: outValid high after reset before any issue", testName);
    end
  end
  issueInstr(OP_ALU, 6'd5, 6'd7);
  advance();
  issueInstr(OP_LOAD, 6'd0, 6'd63);
  advance();
  issueInstr(OP_STORE, 6'd12, 6'd12);
  advance();
  drain();
endtask

task automatic perFuForwarding();
  logic [`TAG_WIDTH-1:0] tag;
  testName = "perFuForwarding";
  for (int fu = 0; fu < `NUM_FU; fu++) begin
    tag = 6'(8 + fu);
    wake(fu, tag, $urandom); // live path on A
    issueInstr(OP_ALU, tag, 6'd1);
    advance();
    wake(fu, 6'(30 + fu), $urandom);
    advance();
    issueInstr(OP_LOAD, 6'd2, 6'(30 + fu)); // history path on B
    advance();
    drain();
  end
endtask

task automatic matchPriority();
  testName = "matchPriority";
  wake(1, 6'd12, $urandom);
  advance();
  wake(4, 6'd12, $urandom); // live beats old
  issueInstr(OP_ALU, 6'd12, 6'd12);
  advance();
  wake(3, 6'd20, $urandom);
  wake(6, 6'd20, $urandom);
  issueInstr(OP_ALU, 6'd20, 6'd3);
  advance();
  wake(8, 6'd21, $urandom);
  wake(5, 6'd21, $urandom);
  advance();
  issueInstr(OP_STORE, 6'd40, 6'd21); // old path, lower index too
  advance();
  wake(0, 6'd0, $urandom);
  wake(2, 6'd0, $urandom);
  issueInstr(OP_ALU, 6'd0, 6'd0);
  advance();
  issueInstr(OP_LOAD, 6'd0, 6'd0); // zero tag in history too
  advance();
  drain();
endtask

task automatic jalrLink();
  testName = "jalrLink";
  issueInstr(OP_JALR, 6'd4, 6'd33);
  advance();
  wake(7, 6'd33, $urandom);
  advance();
  issueInstr(OP_JALR, 6'd33, 6'd33); // A old, B still link
  advance();
  wake(2, 6'd34, $urandom);
  issueInstr(OP_JALR, 6'd5, 6'd34); // live beats link
  advance();
  drain();
endtask

task automatic stallHold();
  logic [`DATA_WIDTH-1:0] heldA;
  logic [`DATA_WIDTH-1:0] heldB;
  logic [`DATA_WIDTH-1:0] heldOp;
  testName = "stallHold";
  wake(2, 6'd30, $urandom);
  issueInstr(OP_ALU, 6'd10, 6'd11);
  advance();
  wake(9, 6'd31, $urandom);
  issueInstr(OP_LOAD, 6'd31, 6'd30); // waits in the match stage through the stall
  advance();
  heldA  = expA[0]; // first instruction is what the outputs hold
  heldB  = expB[0];
  heldOp = 32'(expOp[0]);
  stallNow = 1'b1;
  advance();
  for (int n = 0; n < 5; n++) begin
    if (n == 4) begin
      stallNow = 1'b0;
    end
    advance();
    checkField("stallHold hold", "opA", heldA, opA);
    checkField("stallHold hold", "opB", heldB, opB);
    checkField("stallHold hold", "outOp", heldOp, 32'(outOp));
  end
  issueInstr(OP_STORE, 6'd31, 6'd30);
  advance();
  advance();
  advance();
  @(posedge clk);
  checks++;
  assert (expA.size() == 0) else begin
    errors++;
    $display("%s: issue after the stall did not complete in two cycles", testName);
  end
  drain();
endtask

task automatic backToBack();
  testName = "backToBack";
  wake(2, 6'd5, $urandom);
  issueInstr(OP_ALU, 6'd5, 6'd9);
  advance();
  wake(7, 6'd9, $urandom);
  issueInstr(OP_LOAD, 6'd5, 6'd9);
  advance();
  wake(2, 6'd14, $urandom); // same FU, new result
  issueInstr(OP_STORE, 6'd14, 6'd9);
  advance();
  issueInstr(OP_ALU, 6'd14, 6'd9);
  advance();
  drain();
endtask

`endif

/* dv/issueOperandsTb.sv */
`timescale 1ns/1ps
`include "fwdMacros_macros.svh"

module issueOperandsTb;
  import fwdPkg::*;

  localparam int RESET_CYCLES = 16;
  // rough per-test lengths: rf only, 10 FUs, priority, jalr, stall, back to back
  localparam int TEST_CYCLES  = 12 + 10 * 8 + 14 + 10 + 16 + 10;
  localparam int MAX_CYCLES   = RESET_CYCLES + TEST_CYCLES + 50;

  logic                                clk;
  logic                                rst;
  logic                                stall;
  logic                                inValid;
  opcode_e                             inOp;
  logic [`TAG_WIDTH-1:0]               srcTagA;
  logic [`TAG_WIDTH-1:0]               srcTagB;
  logic [`DATA_WIDTH-1:0]              rfDataA;
  logic [`DATA_WIDTH-1:0]              rfDataB;
  logic [`DATA_WIDTH-1:0]              link;
  logic [`NUM_FU-1:0]                  fuWakeValid;
  logic [`NUM_FU-1:0][`TAG_WIDTH-1:0]  fuWakeTag;
  logic [`NUM_FU-1:0][`DATA_WIDTH-1:0] fuResult;
  logic                                outValid;
  opcode_e                             outOp;
  logic [`DATA_WIDTH-1:0]              opA;
  logic [`DATA_WIDTH-1:0]              opB;

  // wakeups for the cycle being set up, and the ones already on the bus
  logic [`NUM_FU-1:0]                  curValid;
  logic [`NUM_FU-1:0][`TAG_WIDTH-1:0]  curTag;
  logic [`NUM_FU-1:0][`DATA_WIDTH-1:0] curData;
  logic [`NUM_FU-1:0]                  prevValid;
  logic [`NUM_FU-1:0][`TAG_WIDTH-1:0]  prevTag;
  logic [`NUM_FU-1:0][`DATA_WIDTH-1:0] prevData;

  logic                   issueNow;
  logic                   stallNow;
  opcode_e                issueOp;
  logic [`TAG_WIDTH-1:0]  issueTagA;
  logic [`TAG_WIDTH-1:0]  issueTagB;
  logic [`DATA_WIDTH-1:0] issueRfA;
  logic [`DATA_WIDTH-1:0] issueRfB;
  logic [`DATA_WIDTH-1:0] issueLink;
  string                  testName;

  // expected results in issue order
  string                  expName[$];
  opcode_e                expOp[$];
  logic [`DATA_WIDTH-1:0] expA[$];
  logic [`DATA_WIDTH-1:0] expB[$];
  int                     issueEdge[$]; // unstalled edge count at issue

  int   errors = 0;
  int   checks = 0;
  int   cycles = 0;
  int   liveEdges = 0;
  logic edgeAdvanced = 1'b0;

  issueOperands DUT (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .inValid     (inValid),
    .inOp        (inOp),
    .srcTagA     (srcTagA),
    .srcTagB     (srcTagB),
    .rfDataA     (rfDataA),
    .rfDataB     (rfDataB),
    .link        (link),
    .fuWakeValid (fuWakeValid),
    .fuWakeTag   (fuWakeTag),
    .fuResult    (fuResult),
    .outValid    (outValid),
    .outOp       (outOp),
    .opA         (opA),
    .opB         (opB)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    edgeAdvanced <= !rst && !stall; // outputs only move on these edges
    if (!rst && !stall) begin
      liveEdges <= liveEdges + 1;
    end
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
      $display("checks: %0d, errors: %0d", checks, errors + 1);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic checkField(input string name, input string field,
                            input logic [`DATA_WIDTH-1:0] expected,
                            input logic [`DATA_WIDTH-1:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("Mismatch in %s: %s expected %h, actual %h", name, field, expected, actual);
    end
  endtask

  task automatic compareOutputs();
    string name;
    name = expName.pop_front();
    checkField(name, "latency", 32'd2, 32'(liveEdges - issueEdge.pop_front()));
    checkField(name, "outOp", 32'(expOp.pop_front()), 32'(outOp));
    checkField(name, "opA", expA.pop_front(), opA);
    checkField(name, "opB", expB.pop_front(), opB);
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (edgeAdvanced && outValid) begin
      assert (expA.size() > 0) else begin
        errors++;
        $display("outValid went high with no instruction in flight");
      end
      if (expA.size() > 0) begin
        compareOutputs();
      end
    end
  end

  // forwarding rule: live wakeup, then last cycle's wakeup, then link or rf
  function automatic logic [`DATA_WIDTH-1:0] expectOperand(
    input logic [`TAG_WIDTH-1:0]  tag,
    input logic                   jalrB,
    input logic [`DATA_WIDTH-1:0] rf,
    input logic [`DATA_WIDTH-1:0] lnk
  );
    logic [`DATA_WIDTH-1:0] value;
    logic                   found;
    value = jalrB ? lnk : rf;
    found = 1'b0;
    if (tag != '0) begin // zero register never forwards
      for (int i = 0; i < `NUM_FU; i++) begin
        if (!found && curValid[i] && curTag[i] == tag) begin
          value = curData[i];
          found = 1'b1;
        end
      end
      for (int i = 0; i < `NUM_FU; i++) begin
        if (!found && !jalrB && prevValid[i] && prevTag[i] == tag) begin
          value = prevData[i];
          found = 1'b1;
        end
      end
    end
    return value;
  endfunction

  task automatic wake(input int fu, input logic [`TAG_WIDTH-1:0] tag,
                      input logic [`DATA_WIDTH-1:0] data);
    curValid[fu] = 1'b1;
    curTag[fu]   = tag;
    curData[fu]  = data;
  endtask

  task automatic issueInstr(input opcode_e op, input logic [`TAG_WIDTH-1:0] tagA,
                            input logic [`TAG_WIDTH-1:0] tagB);
    issueNow  = 1'b1;
    issueOp   = op;
    issueTagA = tagA;
    issueTagB = tagB;
    issueRfA  = $urandom;
    issueRfB  = $urandom;
    issueLink = $urandom;
  endtask

  // one falling edge: apply the prepared cycle and note what to expect
  task automatic advance();
    @(negedge clk);
    for (int i = 0; i < `NUM_FU; i++) begin
      if (prevValid[i]) begin
        fuResult[i] = prevData[i]; // result trails its wakeup by a cycle
      end
    end
    fuWakeValid = curValid;
    fuWakeTag   = curTag;
    stall       = stallNow;
    inValid     = issueNow;
    inOp        = issueOp;
    srcTagA     = issueTagA;
    srcTagB     = issueTagB;
    rfDataA     = issueRfA;
    rfDataB     = issueRfB;
    link        = issueLink;
    if (issueNow) begin
      expName.push_back(testName);
      expOp.push_back(issueOp);
      expA.push_back(expectOperand(issueTagA, 1'b0, issueRfA, issueLink));
      expB.push_back(expectOperand(issueTagB, issueOp == OP_JALR, issueRfB, issueLink));
      issueEdge.push_back(liveEdges);
    end
    prevValid = curValid;
    prevTag   = curTag;
    prevData  = curData;
    curValid  = '0;
    issueNow  = 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(posedge clk); // checker at the last falling edge is done
    while (expA.size() > 0 && waited < 8) begin
      advance();
      @(posedge clk);
      waited++;
    end
    checks++;
    assert (expA.size() == 0) else begin
      errors++;
      $display("%s: %0d expected results never reached the outputs", testName, expA.size());
    end
  endtask

  `include "issueTests.svh"

  initial begin
    void'($urandom(32'hb4b));
    rst         = 1'b1;
    stall       = 1'b0;
    inValid     = 1'b0;
    inOp        = OP_ALU;
    srcTagA     = '0;
    srcTagB     = '0;
    rfDataA     = '0;
    rfDataB     = '0;
    link        = '0;
    fuWakeValid = '0;
    fuWakeTag   = '0;
    fuResult    = '0;
    curValid    = '0;
    curTag      = '0;
    curData     = '0;
    prevValid   = '0;
    prevTag     = '0;
    prevData    = '0;
    issueNow    = 1'b0;
    stallNow    = 1'b0;
    issueOp     = OP_ALU;
    issueTagA   = '0;
    issueTagB   = '0;
    issueRfA    = '0;
    issueRfB    = '0;
    issueLink   = '0;
    testName    = "reset";
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;

    rfOnlyIssue();
    perFuForwarding();
    matchPriority();
    jalrLink();
    stallHold();
    backToBack();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* hdl/fwdIfc.sv */
`timescale 1ns/1ps
`include "fwdMacros_macros.svh"

interface resultBus;
  logic [`NUM_FU-1:0]                  wakeValid; // announced one cycle before result
  logic [`NUM_FU-1:0][`TAG_WIDTH-1:0]  wakeTag;
  logic [`NUM_FU-1:0][`DATA_WIDTH-1:0] result;

  // one cycle old copies
  logic [`NUM_FU-1:0]                  lastValid;
  logic [`NUM_FU-1:0][`TAG_WIDTH-1:0]  lastTag;
  logic [`NUM_FU-1:0][`DATA_WIDTH-1:0] lastResult;

  modport hist (input wakeValid, wakeTag, result,
                output lastValid, lastTag, lastResult);
  modport match (input wakeValid, wakeTag, lastValid, lastTag);
  modport fwd (input result, lastResult);
endinterface

interface stageBus;
  import fwdPkg::*;

  logic                   valid;
  opcode_e                op;
  fwdSrc_e                srcLiveA;
  fwdSrc_e                srcOldA;
  fwdSrc_e                srcLiveB;
  fwdSrc_e                srcOldB;
  logic [`DATA_WIDTH-1:0] rfDataA;
  logic [`DATA_WIDTH-1:0] rfDataB;
  logic [`DATA_WIDTH-1:0] link;

  modport match (output valid, op, srcLiveA, srcOldA, srcLiveB, srcOldB,
                 rfDataA, rfDataB, link);
  modport fwd (input valid, op, srcLiveA, srcOldA, srcLiveB, srcOldB,
               rfDataA, rfDataB, link);
endinterface

/* hdl/fwdMacros_macros.svh */
`ifndef FWD_MACROS_SVH
`define FWD_MACROS_SVH

// operand width
`define DATA_WIDTH 32

// physical register tag, tag 0 is the zero register
`define TAG_WIDTH 6

// functional units on the result bus
`define NUM_FU 10

// forward source width and the "no match" code
`define FWD_SRC_WIDTH 4
`define NO_FWD 4'hf

`endif

/* hdl/fwdPkg.sv */
`include "fwdMacros_macros.svh"

package fwdPkg;

  // only OP_JALR changes forwarding
  typedef enum logic [1:0] {
    OP_ALU   = 2'd0,
    OP_LOAD  = 2'd1,
    OP_JALR  = 2'd2,
    OP_STORE = 2'd3
  } opcode_e;

  // codes 0..9 name the FU, SRC_NONE means no match
  typedef enum logic [`FWD_SRC_WIDTH-1:0] {
    SRC_FU0  = 4'd0,
    SRC_FU1  = 4'd1,
    SRC_FU2  = 4'd2,
    SRC_FU3  = 4'd3,
    SRC_FU4  = 4'd4,
    SRC_FU5  = 4'd5,
    SRC_FU6  = 4'd6,
    SRC_FU7  = 4'd7,
    SRC_FU8  = 4'd8,
    SRC_FU9  = 4'd9,
    SRC_NONE = `NO_FWD
  } fwdSrc_e;

endpackage

/* hdl/issueOperands.sv */
`timescale 1ns/1ps
`include "fwdMacros_macros.svh"

module issueOperands (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                stall,
  input  logic                                inValid,
  input  fwdPkg::opcode_e                     inOp,
  input  logic [`TAG_WIDTH-1:0]               srcTagA,
  input  logic [`TAG_WIDTH-1:0]               srcTagB,
  input  logic [`DATA_WIDTH-1:0]              rfDataA,
  input  logic [`DATA_WIDTH-1:0]              rfDataB,
  input  logic [`DATA_WIDTH-1:0]              link,
  input  logic [`NUM_FU-1:0]                  fuWakeValid,
  input  logic [`NUM_FU-1:0][`TAG_WIDTH-1:0]  fuWakeTag,
  input  logic [`NUM_FU-1:0][`DATA_WIDTH-1:0] fuResult,
  output logic                                outValid,
  output fwdPkg::opcode_e                     outOp,
  output logic [`DATA_WIDTH-1:0]              opA,
  output logic [`DATA_WIDTH-1:0]              opB
);
  import fwdPkg::*;

  logic validA;
  logic validB;
  logic jalrStaged;

  resultBus rBus ();
  stageBus  sBus ();

  assign rBus.wakeValid = fuWakeValid;
  assign rBus.wakeTag   = fuWakeTag;
  assign rBus.result    = fuResult;

  resultHistory hist (
    .clk (clk),
    .rst (rst),
    .bus (rBus.hist)
  );

  wakeupMatch match (
    .clk     (clk),
    .rst     (rst),
    .stall   (stall),
    .inValid (inValid),
    .inOp    (inOp),
    .srcTagA (srcTagA),
    .srcTagB (srcTagB),
    .rfDataA (rfDataA),
    .rfDataB (rfDataB),
    .link    (link),
    .bus     (rBus.match),
    .stage   (sBus.match)
  );

  assign jalrStaged = (sBus.op == OP_JALR); // link only ever feeds operand B

  operandForward fwdA (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .useLink  (1'b0),
    .srcLive  (sBus.srcLiveA),
    .srcOld   (sBus.srcOldA),
    .rfData   (sBus.rfDataA),
    .link     (sBus.link),
    .bus      (rBus.fwd),
    .validIn  (sBus.valid),
    .validOut (validA),
    .operand  (opA)
  );

  operandForward fwdB (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .useLink  (jalrStaged),
    .srcLive  (sBus.srcLiveB),
    .srcOld   (sBus.srcOldB),
    .rfData   (sBus.rfDataB),
    .link     (sBus.link),
    .bus      (rBus.fwd),
    .validIn  (sBus.valid),
    .validOut (validB),
    .operand  (opB)
  );

  assign outValid = validA & validB; // both lanes advance together

  // opcode rides alongside the forward stage
  always_ff @(posedge clk) begin
    if (rst) begin
      outOp <= OP_ALU;
    end else if (!stall) begin
      outOp <= sBus.op;
    end
  end

endmodule

/* hdl/operandForward.sv */
`timescale 1ns/1ps
`include "fwdMacros_macros.svh"

module operandForward (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall,
  input  logic                   useLink,
  input  fwdPkg::fwdSrc_e        srcLive,
  input  fwdPkg::fwdSrc_e        srcOld,
  input  logic [`DATA_WIDTH-1:0] rfData,
  input  logic [`DATA_WIDTH-1:0] link,
  resultBus.fwd                  bus,
  input  logic                   validIn,
  output logic                   validOut,
  output logic [`DATA_WIDTH-1:0] operand
);
  import fwdPkg::*;

  logic [`DATA_WIDTH-1:0] liveData;
  logic [`DATA_WIDTH-1:0] oldData;
  logic [`DATA_WIDTH-1:0] operandNext;

  // pick the FU slot named by each code
  always_comb begin
    liveData = '0;
    oldData  = '0;
    for (int i = 0; i < `NUM_FU; i++) begin
      if (srcLive == fwdSrc_e'(i)) begin
        liveData = bus.result[i];
      end
      if (srcOld == fwdSrc_e'(i)) begin
        oldData = bus.lastResult[i];
      end
    end
  end

  // live result first; link overrides the history path and rf value
  always_comb begin
    if (srcLive != SRC_NONE) begin
      operandNext = liveData;
    end else if (srcOld != SRC_NONE && !useLink) begin
      operandNext = oldData;
    end else if (useLink) begin
      operandNext = link;
    end else begin
      operandNext = rfData;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      validOut <= 1'b0;
      operand  <= '0;
    end else if (!stall) begin
      validOut <= validIn;
      operand  <= operandNext; // held while stalled
    end
  end

endmodule

/* hdl/resultHistory.sv */
`timescale 1ns/1ps
`include "fwdMacros_macros.svh"

module resultHistory (
  input logic clk,
  input logic rst,
  resultBus.hist bus
);

  // wakeup valids, cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      bus.lastValid <= '0;
    end else begin
      bus.lastValid <= bus.wakeValid; // keeps tracking through a stall
    end
  end

  // tags follow the bus every cycle
  always_ff @(posedge clk) begin
    bus.lastTag <= bus.wakeTag;
  end

  // per FU result capture
  // the result in this cycle belongs to the wakeup seen last cycle,
  // so only load the slot when that wakeup was valid
  genvar i;
  generate
    for (i = 0; i < `NUM_FU; i++) begin : gFu
      always_ff @(posedge clk) begin
        if (bus.lastValid[i]) begin
          bus.lastResult[i] <= bus.result[i];
        end
      end
    end
  endgenerate

endmodule

/* hdl/wakeupMatch.sv */
`timescale 1ns/1ps
`include "fwdMacros_macros.svh"

module wakeupMatch (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall,
  input  logic                   inValid,
  input  fwdPkg::opcode_e        inOp,
  input  logic [`TAG_WIDTH-1:0]  srcTagA,
  input  logic [`TAG_WIDTH-1:0]  srcTagB,
  input  logic [`DATA_WIDTH-1:0] rfDataA,
  input  logic [`DATA_WIDTH-1:0] rfDataB,
  input  logic [`DATA_WIDTH-1:0] link,
  resultBus.match                bus,
  stageBus.match                 stage
);
  import fwdPkg::*;

  fwdSrc_e liveA;
  fwdSrc_e oldA;
  fwdSrc_e liveB;
  fwdSrc_e oldB;

  // lowest matching FU index, tag 0 never matches
  function automatic fwdSrc_e findSrc(
    input logic [`TAG_WIDTH-1:0]                tag,
    input logic [`NUM_FU-1:0]                   valid,
    input logic [`NUM_FU-1:0][`TAG_WIDTH-1:0]   tags
  );
    fwdSrc_e code;
    code = SRC_NONE;
    for (int i = `NUM_FU - 1; i >= 0; i--) begin // walk down so low index wins
      if (valid[i] && tags[i] == tag && tag != '0) begin
        code = fwdSrc_e'(i);
      end
    end
    return code;
  endfunction

  always_comb begin
    liveA = findSrc(srcTagA, bus.wakeValid, bus.wakeTag); // result shows next cycle
    liveB = findSrc(srcTagB, bus.wakeValid, bus.wakeTag);
    oldA  = findSrc(srcTagA, bus.lastValid, bus.lastTag); // result is on the bus now
    oldB  = findSrc(srcTagB, bus.lastValid, bus.lastTag);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stage.valid    <= 1'b0;
      stage.op       <= OP_ALU;
      stage.srcLiveA <= SRC_NONE;
      stage.srcOldA  <= SRC_NONE;
      stage.srcLiveB <= SRC_NONE;
      stage.srcOldB  <= SRC_NONE;
      stage.rfDataA  <= '0;
      stage.rfDataB  <= '0;
      stage.link     <= '0;
    end else if (!stall) begin
      stage.valid    <= inValid;
      stage.op       <= inOp;
      stage.srcLiveA <= liveA;
      stage.srcOldA  <= oldA;
      stage.srcLiveB <= liveB;
      stage.srcOldB  <= oldB;
      stage.rfDataA  <= rfDataA;
      stage.rfDataB  <= rfDataB;
      stage.link     <= link;
    end
  end

endmodule

/* list.f */
+incdir+hdl
+incdir+dv
hdl/fwdPkg.sv
hdl/fwdIfc.sv
hdl/resultHistory.sv
hdl/wakeupMatch.sv
hdl/operandForward.sv
hdl/issueOperands.sv
dv/issueOperandsTb.sv
